// File: alu_pkg.sv
package alu_pkg;

        // Datapath width.
        localparam int DATA_W = 32;

        // Distance from pc_plus_8 back to the next instruction.
        localparam int PC_OFFSET = 4;

        typedef logic [DATA_W-1:0] word_t;

        // ARM data-processing encodings, CLZ placed above them.
        typedef enum logic [4:0] {
                AND = 5'd0,
                EOR = 5'd1,
                SUB = 5'd2,
                RSB = 5'd3,
                ADD = 5'd4,
                ADC = 5'd5,
                SBC = 5'd6,
                RSC = 5'd7,
                TST = 5'd8,
                TEQ = 5'd9,
                CMP = 5'd10,
                CMN = 5'd11,
                ORR = 5'd12,
                MOV = 5'd13,
                BIC = 5'd14,
                MVN = 5'd15,
                CLZ = 5'd16
        } alu_op_t;

        // Condition field, bits 31:28 of the instruction.
        typedef enum logic [3:0] {
                EQ, NE, CS, CC,
                MI, PL, VS, VC,
                HI, LS, GE, LT,
                GT, LE, AL, NV
        } cond_t;

        typedef struct packed {
                logic n;
                logic z;
                logic c;
                logic v;
        } flags_t;

endpackage

// File: exec_if.sv
`timescale 1ns/1ps

interface exec_if;
        import alu_pkg::*;

        flags_t flags_cur; // Flags held by the stage.
        logic   cond_ok;   // Instruction passes its condition.
        word_t  result;
        flags_t flags_nxt; // Flags after this instruction.

        modport ctrl (
                output flags_cur,
                input  cond_ok, result, flags_nxt
        );

        modport cond (
                input  flags_cur,
                output cond_ok
        );

        modport dp (
                input  flags_cur,
                output result, flags_nxt
        );
endinterface

// File: alu_cond_check.sv
`timescale 1ns/1ps

module alu_cond_check (
        exec_if.cond           if_e,
        input alu_pkg::cond_t  i_cond
);
        import alu_pkg::*;

        logic n, z, c, v;

        assign {n, z, c, v} = if_e.flags_cur;

        always_comb
        begin
                case (i_cond)
                EQ:      if_e.cond_ok = z;
                NE:      if_e.cond_ok = !z;
                CS:      if_e.cond_ok = c;
                CC:      if_e.cond_ok = !c;
                MI:      if_e.cond_ok = n;
                PL:      if_e.cond_ok = !n;
                VS:      if_e.cond_ok = v;
                VC:      if_e.cond_ok = !v;
                HI:      if_e.cond_ok = c && !z;
                LS:      if_e.cond_ok = !c || z;
                GE:      if_e.cond_ok = (n == v);         // Signed greater or equal.
                LT:      if_e.cond_ok = (n != v);
                GT:      if_e.cond_ok = (n == v) && !z;
                LE:      if_e.cond_ok = (n != v) || z;
                AL:      if_e.cond_ok = 1'b1;
                NV:      if_e.cond_ok = 1'b0;             // Never executes.
                default: if_e.cond_ok = 1'b0;
                endcase
        end

endmodule

// File: alu_datapath.sv
`timescale 1ns/1ps

module alu_datapath (
        exec_if.dp               if_e,
        input alu_pkg::alu_op_t  i_op,
        input alu_pkg::word_t    i_rn,
        input alu_pkg::word_t    i_rm,
        input logic              i_shift_carry,
        input logic              i_rrx,
        input logic              i_flag_update
);
        import alu_pkg::*;

        localparam int CLZ_W = $clog2(DATA_W) + 1;

        word_t             rm_op;      // Second operand after RRX.
        logic              log_carry;
        word_t             log_res;
        logic              is_arith;
        word_t             add_a, add_b;
        logic              add_cin;
        logic [DATA_W:0]   sum;
        logic [CLZ_W-1:0]  clz_cnt;
        logic              clz_found;
        word_t             res;

        // RRX shifts the old carry in at the top, bit 0 falls out as carry.
        assign rm_op     = i_rrx ? {if_e.flags_cur.c, i_rm[DATA_W-1:1]} : i_rm;
        assign log_carry = i_rrx ? i_rm[0] : i_shift_carry;

        always_comb
        begin
                clz_cnt   = CLZ_W'(DATA_W); // All zeros counts as full width.
                clz_found = 1'b0;
                for (int i = DATA_W - 1; i >= 0; i--)
                begin
                        if (!clz_found && rm_op[i])
                        begin
                                clz_cnt   = CLZ_W'(DATA_W - 1 - i);
                                clz_found = 1'b1;
                        end
                end
        end

        always_comb
        begin
                log_res = '0;
                case (i_op)
                AND, TST: log_res = i_rn & rm_op;
                EOR, TEQ: log_res = i_rn ^ rm_op;
                ORR:      log_res = i_rn | rm_op;
                BIC:      log_res = i_rn & ~rm_op;
                MOV:      log_res = rm_op;
                MVN:      log_res = ~rm_op;
                CLZ:      log_res = DATA_W'(clz_cnt);
                default:  log_res = '0;
                endcase
        end

        // Every arithmetic op reduces to a + b + cin.
        always_comb
        begin
                is_arith = 1'b1;
                add_a    = i_rn;
                add_b    = rm_op;
                add_cin  = 1'b0;
                case (i_op)
                ADD, CMN: add_cin = 1'b0;
                ADC:      add_cin = if_e.flags_cur.c;
                SUB, CMP:
                begin
                        add_b   = ~rm_op;
                        add_cin = 1'b1;
                end
                SBC:
                begin
                        add_b   = ~rm_op;
                        add_cin = if_e.flags_cur.c; // Borrow is the inverted carry.
                end
                RSB:
                begin
                        add_a   = rm_op;
                        add_b   = ~i_rn;
                        add_cin = 1'b1;
                end
                RSC:
                begin
                        add_a   = rm_op;
                        add_b   = ~i_rn;
                        add_cin = if_e.flags_cur.c;
                end
                default:  is_arith = 1'b0;
                endcase
        end

        assign sum = {1'b0, add_a} + {1'b0, add_b} + (DATA_W + 1)'(add_cin);
        assign res = is_arith ? sum[DATA_W-1:0] : log_res;

        always_comb
        begin
                if_e.result    = res;
                if_e.flags_nxt = if_e.flags_cur;
                if (i_flag_update)
                begin
                        if_e.flags_nxt.n = res[DATA_W-1];
                        if_e.flags_nxt.z = (res == '0);
                        if (is_arith)
                        begin
                                if_e.flags_nxt.c = sum[DATA_W];
                                if_e.flags_nxt.v = (add_a[DATA_W-1] == add_b[DATA_W-1]) &&
                                                   (res[DATA_W-1] != add_a[DATA_W-1]);
                        end
                        else
                        begin
                                if_e.flags_nxt.c = log_carry; // V kept.
                        end
                end
        end

endmodule

// File: alu_stage_ctrl.sv
`timescale 1ns/1ps

module alu_stage_ctrl #(
        parameter int unsigned REG_IDX_W   = 6,
        parameter int unsigned ARCH_PC_IDX = 15,
        parameter int unsigned RAZ_IDX     = 0
) (
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  logic                  i_clear,
        input  alu_pkg::flags_t       i_flags_restore,
        input  logic                  i_stall,
        exec_if.ctrl                  if_e,

        input  logic                  i_flag_update,
        input  logic [REG_IDX_W-1:0]  i_dest_index,
        input  alu_pkg::word_t        i_pc_plus_8,
        input  logic                  i_exception,
        input  alu_pkg::word_t        i_rn,
        input  logic                  i_mem_pre_index,
        input  logic                  i_mem_load,
        input  logic                  i_mem_store,
        input  logic [REG_IDX_W-1:0]  i_mem_srcdest_index,
        input  alu_pkg::word_t        i_mem_data,

        output alu_pkg::word_t        o_result,
        output logic                  o_dav,
        output alu_pkg::flags_t       o_flags,
        output logic [REG_IDX_W-1:0]  o_dest_index,
        output alu_pkg::word_t        o_mem_address,
        output logic                  o_mem_load,
        output logic                  o_mem_store,
        output alu_pkg::word_t        o_mem_data,
        output logic                  o_exception,

        output logic                  o_clear_from_alu,
        output alu_pkg::word_t        o_pc_from_alu
);
        import alu_pkg::*;

        localparam logic [REG_IDX_W-1:0] PC_IDX  = REG_IDX_W'(ARCH_PC_IDX);
        localparam logic [REG_IDX_W-1:0] RAZ_REG = REG_IDX_W'(RAZ_IDX);

        flags_t                flags_ff;
        logic                  sleep_ff, sleep_nxt;
        logic                  dav_nxt;
        logic                  quick_branch;
        logic [REG_IDX_W-1:0]  dest_nxt;
        word_t                 mem_address_nxt;

        assign if_e.flags_cur = flags_ff;
        assign o_flags        = flags_ff;

        always_comb
        begin
                dav_nxt      = if_e.cond_ok && !i_exception;
                sleep_nxt    = 1'b0;
                quick_branch = 1'b0;
                dest_nxt     = i_dest_index;

                if (i_exception)
                        sleep_nxt = 1'b1;                       // Exception handled in writeback.
                else if (if_e.cond_ok && i_dest_index == PC_IDX && i_flag_update)
                        sleep_nxt = 1'b1;
                else if (if_e.cond_ok && i_dest_index == PC_IDX)
                begin
                        quick_branch = 1'b1;
                        dest_nxt     = RAZ_REG;                 // PC already redirected.
                end
                else if (if_e.cond_ok && i_mem_load && i_mem_srcdest_index == PC_IDX)
                        sleep_nxt = 1'b1;                       // Load to PC.
        end

        assign mem_address_nxt = i_mem_pre_index ? if_e.result : i_rn;

        // Fetch redirect, no effect while asleep.
        assign o_clear_from_alu = quick_branch && !sleep_ff;
        assign o_pc_from_alu    = o_clear_from_alu ? if_e.result : i_pc_plus_8;

        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_clear)
                begin
                        sleep_ff <= 1'b0;                       // Clear wakes the stage.
                        flags_ff <= i_reset ? '0 : i_flags_restore;
                end
                else if (!i_stall && !sleep_ff)
                begin
                        sleep_ff <= sleep_nxt;
                        if (dav_nxt)
                                flags_ff <= if_e.flags_nxt;
                end
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_clear || (!i_stall && sleep_ff))
                begin
                        o_result      <= '0;
                        o_dav         <= 1'b0;
                        o_dest_index  <= '0;
                        o_mem_address <= '0;
                        o_mem_load    <= 1'b0;
                        o_mem_store   <= 1'b0;
                        o_mem_data    <= '0;
                        o_exception   <= 1'b0;
                end
                else if (!i_stall)
                begin
                        o_result      <= if_e.result;
                        o_dav         <= dav_nxt;
                        o_dest_index  <= dest_nxt;
                        o_mem_address <= mem_address_nxt;
                        o_mem_load    <= i_mem_load;
                        o_mem_store   <= i_mem_store;
                        o_mem_data    <= i_mem_data;
                        o_exception   <= i_exception;
                end
        end

endmodule

// File: alu_stage.sv
`timescale 1ns/1ps

module alu_stage #(
        parameter int unsigned REG_IDX_W   = 6,
        parameter int unsigned ARCH_PC_IDX = 15,
        parameter int unsigned RAZ_IDX     = 0
) (
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  logic                  i_clear,
        input  alu_pkg::flags_t       i_flags_restore,
        input  logic                  i_stall,

        input  alu_pkg::alu_op_t      i_op,
        input  alu_pkg::cond_t        i_cond,
        input  alu_pkg::word_t        i_rn,
        input  alu_pkg::word_t        i_rm,
        input  logic                  i_shift_carry,
        input  logic                  i_rrx,
        input  logic                  i_flag_update,
        input  logic [REG_IDX_W-1:0]  i_dest_index,
        input  alu_pkg::word_t        i_pc_plus_8,
        input  logic                  i_exception,
        input  logic                  i_mem_pre_index,
        input  logic                  i_mem_load,
        input  logic                  i_mem_store,
        input  logic [REG_IDX_W-1:0]  i_mem_srcdest_index,
        input  alu_pkg::word_t        i_mem_data,

        output alu_pkg::word_t        o_result,
        output logic                  o_dav,
        output alu_pkg::flags_t       o_flags,
        output logic [REG_IDX_W-1:0]  o_dest_index,
        output alu_pkg::word_t        o_mem_address,
        output logic                  o_mem_load,
        output logic                  o_mem_store,
        output alu_pkg::word_t        o_mem_data,
        output logic                  o_exception,
        output logic                  o_clear_from_alu,
        output alu_pkg::word_t        o_pc_from_alu
);

        exec_if exec_i ();

        alu_cond_check cond_i (
                .if_e   (exec_i.cond),
                .i_cond (i_cond)
        );

        alu_datapath dp_i (
                .if_e          (exec_i.dp),
                .i_op          (i_op),
                .i_rn          (i_rn),
                .i_rm          (i_rm),
                .i_shift_carry (i_shift_carry),
                .i_rrx         (i_rrx),
                .i_flag_update (i_flag_update)
        );

        alu_stage_ctrl #(
                .REG_IDX_W   (REG_IDX_W),
                .ARCH_PC_IDX (ARCH_PC_IDX),
                .RAZ_IDX     (RAZ_IDX)
        ) ctrl_i (
                .i_clk               (i_clk),
                .i_reset             (i_reset),
                .i_clear             (i_clear),
                .i_flags_restore     (i_flags_restore),
                .i_stall             (i_stall),
                .if_e                (exec_i.ctrl),
                .i_flag_update       (i_flag_update),
                .i_dest_index        (i_dest_index),
                .i_pc_plus_8         (i_pc_plus_8),
                .i_exception         (i_exception),
                .i_rn                (i_rn),
                .i_mem_pre_index     (i_mem_pre_index),
                .i_mem_load          (i_mem_load),
                .i_mem_store         (i_mem_store),
                .i_mem_srcdest_index (i_mem_srcdest_index),
                .i_mem_data          (i_mem_data),
                .o_result            (o_result),
                .o_dav               (o_dav),
                .o_flags             (o_flags),
                .o_dest_index        (o_dest_index),
                .o_mem_address       (o_mem_address),
                .o_mem_load          (o_mem_load),
                .o_mem_store         (o_mem_store),
                .o_mem_data          (o_mem_data),
                .o_exception         (o_exception),
                .o_clear_from_alu    (o_clear_from_alu),
                .o_pc_from_alu       (o_pc_from_alu)
        );

endmodule

// File: alu_stage_props.sv
`timescale 1ns/1ps

module alu_stage_props (
        input logic             i_clk,
        input logic             i_reset,
        input logic             i_clear,
        input logic             i_stall,
        input alu_pkg::flags_t  i_flags_restore,
        input alu_pkg::word_t   o_result,
        input logic             o_dav,
        input alu_pkg::flags_t  o_flags,
        input logic             o_clear_from_alu
);

        reset_quiet: assert property (@(posedge i_clk)
                i_reset |=> (!o_dav && !o_clear_from_alu))
                else $error("Stage not quiet after reset");

        stall_holds: assert property (@(posedge i_clk)
                (i_stall && !i_reset && !i_clear) |=> $stable(o_result))
                else $error("Result moved under stall");

        clear_restores: assert property (@(posedge i_clk)
                (i_clear && !i_reset) |=> (o_flags == $past(i_flags_restore)))
                else $error("Flags not restored by clear");

endmodule

bind alu_stage alu_stage_props props_i (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_clear          (i_clear),
        .i_stall          (i_stall),
        .i_flags_restore  (i_flags_restore),
        .o_result         (o_result),
        .o_dav            (o_dav),
        .o_flags          (o_flags),
        .o_clear_from_alu (o_clear_from_alu)
);

// File: tb_alu_stage.sv
`timescale 1ns/1ps

module tb_alu_stage;
        import alu_pkg::*;

        localparam int NUM_VEC   = 68;
        localparam int MAX_CYCLE = 2 * NUM_VEC + 20;

        // One line of the vector file, every field a whole number of hex digits.
        typedef struct packed {
                logic [3:0]  clr, stall, restore;
                logic [7:0]  op;
                logic [3:0]  cond;
                logic [31:0] rn, rm;
                logic [3:0]  shc, rrx, fu;
                logic [7:0]  dest;
                logic [31:0] pc8;
                logic [3:0]  exc, pre, ld, st;
                logic [7:0]  msi;
                logic [31:0] mdata;
                logic [3:0]  e_clr;
                logic [31:0] e_pc;
                logic [31:0] e_res;
                logic [3:0]  e_dav, e_flags;
                logic [7:0]  e_dest;
                logic [31:0] e_addr;
                logic [3:0]  e_ld, e_st, e_exc;
                logic [31:0] e_mdata;
        } vec_t;

        logic [$bits(vec_t)-1:0] vectors [0:NUM_VEC-1];

        logic        i_clk = 1'b0;
        logic        i_reset, i_clear, i_stall;
        flags_t      i_flags_restore;
        alu_op_t     i_op;
        cond_t       i_cond;
        word_t       i_rn, i_rm, i_pc_plus_8, i_mem_data;
        logic        i_shift_carry, i_rrx, i_flag_update, i_exception;
        logic        i_mem_pre_index, i_mem_load, i_mem_store;
        logic [5:0]  i_dest_index, i_mem_srcdest_index;
        word_t       o_result, o_mem_address, o_mem_data, o_pc_from_alu;
        logic        o_dav, o_mem_load, o_mem_store, o_exception, o_clear_from_alu;
        flags_t      o_flags;
        logic [5:0]  o_dest_index;

        int errors = 0;
        int checks = 0;
        int cycles = 0;
        int cur_line = 0;

        alu_stage #(.REG_IDX_W(6)) dut_i (.*);

        always #2 i_clk = ~i_clk;

        // Guards against a stuck run.
        always @(posedge i_clk)
        begin
                cycles <= cycles + 1;
                if (cycles >= MAX_CYCLE)
                begin
                        $display("Run timed out after %0d cycles", cycles);
                        $display("Testbench failed");
                        $finish;
                end
        end

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                checks++;
                if (got !== exp)
                begin
                        errors++;
                        $display("** Error at %0t: line %0d %s is %h, expected %h",
                                 $time, cur_line, name, got, exp);
                end
        endtask

        task automatic apply_vector(input vec_t v);
                i_clear             = v.clr[0];
                i_stall             = v.stall[0];
                i_flags_restore     = flags_t'(v.restore);
                i_op                = alu_op_t'(v.op[4:0]);
                i_cond              = cond_t'(v.cond);
                i_rn                = v.rn;
                i_rm                = v.rm;
                i_shift_carry       = v.shc[0];
                i_rrx               = v.rrx[0];
                i_flag_update       = v.fu[0];
                i_dest_index        = v.dest[5:0];
                i_pc_plus_8         = v.pc8;
                i_exception         = v.exc[0];
                i_mem_pre_index     = v.pre[0];
                i_mem_load          = v.ld[0];
                i_mem_store         = v.st[0];
                i_mem_srcdest_index = v.msi[5:0];
                i_mem_data          = v.mdata;
        endtask

        task automatic check_registered(input vec_t v);
                check_value("o_result", o_result, v.e_res);
                check_value("o_dav", 32'(o_dav), 32'(v.e_dav));
                check_value("o_flags", 32'(o_flags), 32'(v.e_flags));
                check_value("o_dest_index", 32'(o_dest_index), 32'(v.e_dest));
                check_value("o_mem_address", o_mem_address, v.e_addr);
                check_value("o_mem_load", 32'(o_mem_load), 32'(v.e_ld));
                check_value("o_mem_store", 32'(o_mem_store), 32'(v.e_st));
                check_value("o_exception", 32'(o_exception), 32'(v.e_exc));
                check_value("o_mem_data", o_mem_data, v.e_mdata);
        endtask

        initial
        begin
                vec_t v;
                $readmemh("alu_golden.mem", vectors);
                i_reset = 1'b1;
                apply_vector('0);
                repeat (4) @(posedge i_clk);

                for (int k = 0; k <= NUM_VEC; k++)
                begin
                        @(negedge i_clk);
                        i_reset = 1'b0;
                        if (k > 0)
                        begin
                                cur_line = k - 1; // Registered results of the last line.
                                check_registered(vec_t'(vectors[k-1]));
                        end
                        if (k < NUM_VEC)
                        begin
                                v = vec_t'(vectors[k]);
                                cur_line = k;
                                apply_vector(v);
                                #1;
                                check_value("o_clear_from_alu", 32'(o_clear_from_alu),
                                            32'(v.e_clr));
                                check_value("o_pc_from_alu", o_pc_from_alu, v.e_pc);
                        end
                end

                $display("Errors: %0d in %0d checks", errors, checks);
                if (errors == 0)
                        $display("Testbench passed");
                else
                        $display("Testbench failed");
                $finish;
        end

endmodule

// File: alu_golden.mem
// clr stall restore_op cond_rn_rm_shc rrx fu dest_pc8_exc pre ld st msi_mdata
// then expected: clr pc_result_dav flags dest_address_ld st exc mdata
000_0de_00000000_12345678_00101_00000100_000000_00000000_000000100_12345678_1001_00000000_00000000000
000_04e_7fffffff_00000001_00102_00000100_000000_00000000_000000100_80000000_1902_7fffffff_00000000000
000_04e_ffffffff_00000001_00103_00000100_000000_00000000_000000100_00000000_1603_ffffffff_00000000000
000_046_00000001_00000001_00103_00000100_000000_00000000_000000100_00000002_0603_00000001_00000000000
000_057_00000010_00000020_00104_00000100_000000_00000000_000000100_00000031_1004_00000010_00000000000
000_02e_00000005_00000007_00105_00000100_000000_00000000_000000100_fffffffe_1805_00000005_00000000000
000_06e_00000010_00000003_00106_00000100_000000_00000000_000000100_0000000c_1206_00000010_00000000000
000_03e_00000003_00000010_00107_00000100_000000_00000000_000000100_0000000d_1207_00000003_00000000000
000_07e_00000001_80000000_00108_00000100_000000_00000000_000000100_7fffffff_1308_00000001_00000000000
000_0ae_00000005_00000005_00100_00000100_000000_00000000_000000100_00000000_1600_00000005_00000000000
000_0be_80000000_80000000_00100_00000100_000000_00000000_000000100_00000000_1700_80000000_00000000000
000_08e_000000f0_0000000f_00100_00000100_000000_00000000_000000100_00000000_1500_000000f0_00000000000
000_09e_80000000_00000000_10100_00000100_000000_00000000_000000100_80000000_1b00_80000000_00000000000
000_00e_ff00ff00_0ff00ff0_00009_00000100_000000_00000000_000000100_0f000f00_1b09_ff00ff00_00000000000
000_01e_0000ffff_00ff00ff_0000a_00000100_000000_00000000_000000100_00ffff00_1b0a_0000ffff_00000000000
000_0ce_f0000000_0000000f_0010b_00000100_000000_00000000_000000100_f000000f_190b_f0000000_00000000000
000_0ee_ffffffff_0000ffff_0000c_00000100_000000_00000000_000000100_ffff0000_190c_ffffffff_00000000000
000_0fe_00000000_00000000_1010d_00000100_000000_00000000_000000100_ffffffff_1b0d_00000000_00000000000
000_10e_00000000_00000000_0000e_00000100_000000_00000000_000000100_00000020_1b0e_00000000_00000000000
000_10e_00000000_00010000_0000e_00000100_000000_00000000_000000100_0000000f_1b0e_00000000_00000000000
000_0de_00000000_00000003_01101_00000100_000000_00000000_000000100_80000001_1b01_00000000_00000000000
000_0d0_00000000_00000000_00102_00000100_000000_00000000_000000100_00000000_0b02_00000000_00000000000
000_0d1_00000000_000000c2_00002_00000100_000000_00000000_000000100_000000c2_1b02_00000000_00000000000
000_0d2_00000000_000000c3_00002_00000100_000000_00000000_000000100_000000c3_1b02_00000000_00000000000
000_0d3_00000000_000000c4_00002_00000100_000000_00000000_000000100_000000c4_0b02_00000000_00000000000
000_0d4_00000000_000000c5_00002_00000100_000000_00000000_000000100_000000c5_1b02_00000000_00000000000
000_0d5_00000000_000000c6_00002_00000100_000000_00000000_000000100_000000c6_0b02_00000000_00000000000
000_0d6_00000000_000000c7_00002_00000100_000000_00000000_000000100_000000c7_1b02_00000000_00000000000
000_0d7_00000000_000000c8_00002_00000100_000000_00000000_000000100_000000c8_0b02_00000000_00000000000
000_0d8_00000000_000000c9_00002_00000100_000000_00000000_000000100_000000c9_1b02_00000000_00000000000
000_0d9_00000000_000000ca_00002_00000100_000000_00000000_000000100_000000ca_0b02_00000000_00000000000
000_0da_00000000_000000cb_00002_00000100_000000_00000000_000000100_000000cb_1b02_00000000_00000000000
000_0db_00000000_000000cc_00002_00000100_000000_00000000_000000100_000000cc_0b02_00000000_00000000000
000_0dc_00000000_000000cd_00002_00000100_000000_00000000_000000100_000000cd_1b02_00000000_00000000000
000_0dd_00000000_000000ce_00002_00000100_000000_00000000_000000100_000000ce_0b02_00000000_00000000000
000_0df_00000000_000000cf_00002_00000100_000000_00000000_000000100_000000cf_0b02_00000000_00000000000
000_09e_5a5a5a5a_5a5a5a5a_00100_00000100_000000_00000000_000000100_00000000_1500_5a5a5a5a_00000000000
000_0d0_00000000_000000d1_00002_00000100_000000_00000000_000000100_000000d1_1502_00000000_00000000000
000_0d1_00000000_000000d2_00002_00000100_000000_00000000_000000100_000000d2_0502_00000000_00000000000
000_0d2_00000000_000000d3_00002_00000100_000000_00000000_000000100_000000d3_0502_00000000_00000000000
000_0d3_00000000_000000d4_00002_00000100_000000_00000000_000000100_000000d4_1502_00000000_00000000000
000_0d4_00000000_000000d5_00002_00000100_000000_00000000_000000100_000000d5_0502_00000000_00000000000
000_0d5_00000000_000000d6_00002_00000100_000000_00000000_000000100_000000d6_1502_00000000_00000000000
000_0d8_00000000_000000d7_00002_00000100_000000_00000000_000000100_000000d7_0502_00000000_00000000000
000_0d9_00000000_000000d8_00002_00000100_000000_00000000_000000100_000000d8_1502_00000000_00000000000
000_0da_00000000_000000d9_00002_00000100_000000_00000000_000000100_000000d9_0502_00000000_00000000000
000_0db_00000000_000000da_00002_00000100_000000_00000000_000000100_000000da_1502_00000000_00000000000
000_0dc_00000000_000000db_00002_00000100_000000_00000000_000000100_000000db_0502_00000000_00000000000
000_0dd_00000000_000000dc_00002_00000100_000000_00000000_000000100_000000dc_1502_00000000_00000000000
000_04e_00001000_00000010_00003_00000100_010104_cafef00d_000000100_00001010_1503_00001010_010cafef00d
000_04e_00002000_00000008_00005_00000100_001005_00000000_000000100_00002008_1505_00002000_10000000000
000_04e_00000100_00000040_0000f_00000100_000000_00000000_100000140_00000140_1500_00000100_00000000000
000_0d1_00000000_00000200_0000f_00000100_000000_00000000_000000100_00000200_050f_00000000_00000000000
000_0de_00000000_00000300_0010f_00000100_000000_00000000_000000100_00000300_110f_00000000_00000000000
000_04e_00000001_00000001_0000f_00000100_000000_00000000_000000100_00000000_0100_00000000_00000000000
106_0de_00000000_00000005_00001_00000100_000000_00000000_000000100_00000000_0600_00000000_00000000000
000_02e_00000009_00000004_00102_00000100_000000_00000000_000000100_00000005_1202_00000009_00000000000
000_0de_00000000_00000007_00103_00000100_100000_00000000_000000100_00000007_0203_00000000_00100000000
000_0de_00000000_00000008_00004_00000100_000000_00000000_000000100_00000000_0200_00000000_00000000000
108_0de_00000000_00000000_00000_00000100_000000_00000000_000000100_00000000_0800_00000000_00000000000
000_04e_00003000_00000004_00006_00000100_01100f_00000000_000000100_00003004_1806_00003004_10000000000
000_0de_00000000_00000009_00007_00000100_000000_00000000_000000100_00000000_0800_00000000_00000000000
100_0de_00000000_00000000_00000_00000100_000000_00000000_000000100_00000000_0000_00000000_00000000000
000_0de_00004000_abcd0123_00008_00000100_000100_11112222_000000100_abcd0123_1008_00004000_01011112222
010_0de_00000000_99999999_00109_00000100_000000_00000000_000000100_abcd0123_1008_00004000_01011112222
010_0de_00000000_99999999_00109_00000100_000000_00000000_000000100_abcd0123_1008_00004000_01011112222
010_0de_00000000_99999999_00109_00000100_000000_00000000_000000100_abcd0123_1008_00004000_01011112222
000_0de_00000000_00000055_0010a_00000100_000000_00000000_000000100_00000055_100a_00000000_00000000000

// File: filelist.f
alu_pkg.sv
exec_if.sv
alu_cond_check.sv
alu_datapath.sv
alu_stage_ctrl.sv
alu_stage.sv
alu_stage_props.sv
tb_alu_stage.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_alu_stage -f filelist.f

out=$(./obj_dir/Vtb_alu_stage)
echo "$out"

# Fails the script unless the pass line is present.
echo "$out" | grep -q "^Testbench passed$"
